// File: mm_pkg.sv
package mm_pkg;

    // Signed operand element holding one int8 matrix entry
    localparam int ELEM_W = 8;

    // Result element
    // Holds the low bits of the exact dot product, so overflow wraps
    localparam int RESULT_W = 16;

    // Target matrix of a buffer write
    typedef enum logic [0:0] {
        OPERAND_A = 1'b0,
        OPERAND_B = 1'b1
    } operand_sel_t;

    // MAC engine FSM
    // RUN walks rows and columns, RELEASE hands the bank back
    typedef enum logic [1:0] {
        ENG_IDLE    = 2'd0,
        ENG_RUN     = 2'd1,
        ENG_RELEASE = 2'd2
    } engine_state_t;

endpackage

// File: operand_loader.sv
module operand_loader #(
    parameter int DIM = 8,
    localparam int ROW_W = DIM * mm_pkg::ELEM_W,
    localparam int IDX_W = $clog2(DIM)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 a_valid,
    input  logic [ROW_W-1:0]     a_data,
    input  logic                 b_valid,
    input  logic [ROW_W-1:0]     b_data,
    output logic                 wr_en,
    output mm_pkg::operand_sel_t wr_sel,
    output logic [IDX_W-1:0]     wr_row,
    output logic [ROW_W-1:0]     wr_data,
    output logic                 fill_done
);

    logic [IDX_W-1:0]     a_cnt;
    logic [IDX_W-1:0]     b_cnt;
    logic                 a_done;
    logic                 b_done;
    logic                 a_last;
    logic                 b_last;
    logic                 pair_done;

    // One-entry skid that always holds an older beat than the inputs
    logic                 skid_valid;
    mm_pkg::operand_sel_t skid_sel;
    logic [IDX_W-1:0]     skid_row;
    logic [ROW_W-1:0]     skid_data;

    assign a_last = a_valid && (a_cnt == IDX_W'(DIM - 1));
    assign b_last = b_valid && (b_cnt == IDX_W'(DIM - 1));

    // Pair completes on the beat that closes the second matrix
    assign pair_done = (a_last || b_last) && (a_last || a_done) && (b_last || b_done);

    // Write port serves the held entry first, then A, then B
    always_comb begin
        wr_en = skid_valid || a_valid || b_valid;
        if (skid_valid) begin
            wr_sel  = skid_sel;
            wr_row  = skid_row;
            wr_data = skid_data;
        end else if (a_valid) begin
            wr_sel  = mm_pkg::OPERAND_A;
            wr_row  = a_cnt;
            wr_data = a_data;
        end else begin
            wr_sel  = mm_pkg::OPERAND_B;
            wr_row  = b_cnt;
            wr_data = b_data;
        end
    end

    // Skid occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            skid_valid <= a_valid || b_valid;
        end else begin
            skid_valid <= a_valid && b_valid;
        end
    end

    // Skid payload takes the beat that lost the write port
    always_ff @(posedge clk) begin
        if (skid_valid && a_valid) begin
            skid_sel  <= mm_pkg::OPERAND_A;
            skid_row  <= a_cnt;
            skid_data <= a_data;
        end else if (b_valid && (skid_valid || a_valid)) begin
            skid_sel  <= mm_pkg::OPERAND_B;
            skid_row  <= b_cnt;
            skid_data <= b_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_cnt     <= '0;
            b_cnt     <= '0;
            a_done    <= 1'b0;
            b_done    <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= pair_done;
            if (a_valid) begin
                a_cnt <= a_last ? '0 : a_cnt + 1'b1;
            end
            if (b_valid) begin
                b_cnt <= b_last ? '0 : b_cnt + 1'b1;
            end
            // Rearm for the next pair
            if (pair_done) begin
                a_done <= 1'b0;
                b_done <= 1'b0;
            end else begin
                if (a_last) begin
                    a_done <= 1'b1;
                end
                if (b_last) begin
                    b_done <= 1'b1;
                end
            end
        end
    end

    // A finished matrix takes no more beats until its partner completes
    a_no_extra_beat: assert property (@(posedge clk) disable iff (rst)
        !(a_valid && a_done) && !(b_valid && b_done));

    // Two fresh beats behind a held entry would need a second skid slot
    a_skid_overflow: assert property (@(posedge clk) disable iff (rst)
        !(skid_valid && a_valid && b_valid));

endmodule

// File: operand_buffer.sv
module operand_buffer #(
    parameter int DIM = 8,
    localparam int EW = mm_pkg::ELEM_W,
    localparam int ROW_W = DIM * EW,
    localparam int IDX_W = $clog2(DIM)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  mm_pkg::operand_sel_t wr_sel,
    input  logic [IDX_W-1:0]     wr_row,
    input  logic [ROW_W-1:0]     wr_data,
    input  logic                 fill_done,
    input  logic [IDX_W-1:0]     rd_row,
    input  logic [IDX_W-1:0]     rd_col,
    input  logic                 bank_release,
    output logic [ROW_W-1:0]     a_row_data,
    output logic [ROW_W-1:0]     b_col_data,
    output logic                 operands_full,
    output logic                 ready
);

    // Two banks, each with DIM rows of A and DIM rows of B
    logic [ROW_W-1:0] a_mem [2][DIM];
    logic [ROW_W-1:0] b_mem [2][DIM];

    logic [1:0] full;
    logic       wr_bank;
    logic       rd_bank;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_sel == mm_pkg::OPERAND_A) begin
                a_mem[wr_bank][wr_row] <= wr_data;
            end else begin
                b_mem[wr_bank][wr_row] <= wr_data;
            end
        end
    end

    // Bank pointers and full flags
    always_ff @(posedge clk) begin
        if (rst) begin
            full    <= 2'b00;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end else begin
            if (fill_done) begin
                full[wr_bank] <= 1'b1;
                wr_bank       <= ~wr_bank;
            end
            if (bank_release) begin
                full[rd_bank] <= 1'b0;
                rd_bank       <= ~rd_bank;
            end
        end
    end

    assign operands_full = full[rd_bank];
    assign ready         = !full[wr_bank];

    assign a_row_data = a_mem[rd_bank][rd_row];

    // Element r of the gathered column comes from stored B row r
    always_comb begin
        for (int r = 0; r < DIM; r++) begin
            b_col_data[r*EW +: EW] = b_mem[rd_bank][r][rd_col*EW +: EW];
        end
    end

    // Host must wait for ready before loading a bank
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full[wr_bank]);

    a_release_full: assert property (@(posedge clk) disable iff (rst)
        bank_release |-> full[rd_bank]);

endmodule

// File: mac_engine.sv
module mac_engine #(
    parameter int DIM = 8,
    localparam int EW = mm_pkg::ELEM_W,
    localparam int RW = mm_pkg::RESULT_W,
    localparam int ROW_W = DIM * EW,
    localparam int C_ROW_W = DIM * RW,
    localparam int IDX_W = $clog2(DIM),
    localparam int ACC_W = 2 * EW + IDX_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               operands_full,
    input  logic [ROW_W-1:0]   a_row_data,
    input  logic [ROW_W-1:0]   b_col_data,
    output logic [IDX_W-1:0]   rd_row,
    output logic [IDX_W-1:0]   rd_col,
    output logic               bank_release,
    output logic               c_valid,
    output logic [C_ROW_W-1:0] c_data,
    output logic               c_last,
    output logic               busy
);

    mm_pkg::engine_state_t state;

    logic signed [ACC_W-1:0] acc;
    logic                    col_end;
    logic                    row_end;

    assign col_end = (rd_col == IDX_W'(DIM - 1));
    assign row_end = (rd_row == IDX_W'(DIM - 1));
    assign busy    = (state != mm_pkg::ENG_IDLE);

    // Exact signed dot product of the current A row and B column
    always_comb begin
        acc = '0;
        for (int k = 0; k < DIM; k++) begin
            acc = acc + $signed(a_row_data[k*EW +: EW]) * $signed(b_col_data[k*EW +: EW]);
        end
    end

    // Result row shift register
    // Newest element enters at the top, so column 0 ends at the bottom
    always_ff @(posedge clk) begin
        if (state == mm_pkg::ENG_RUN) begin
            c_data <= {acc[RW-1:0], c_data[C_ROW_W-1:RW]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= mm_pkg::ENG_IDLE;
            rd_row       <= '0;
            rd_col       <= '0;
            c_valid      <= 1'b0;
            c_last       <= 1'b0;
            bank_release <= 1'b0;
        end else begin
            c_valid      <= 1'b0;
            c_last       <= 1'b0;
            bank_release <= 1'b0;
            case (state)
                mm_pkg::ENG_IDLE: begin
                    // Full flag of a just released bank is still visible here
                    if (operands_full && !bank_release) begin
                        state <= mm_pkg::ENG_RUN;
                    end
                end
                mm_pkg::ENG_RUN: begin
                    if (col_end) begin
                        rd_col  <= '0;
                        c_valid <= 1'b1;
                        if (row_end) begin
                            rd_row <= '0;
                            c_last <= 1'b1;
                            state  <= mm_pkg::ENG_RELEASE;
                        end else begin
                            rd_row <= rd_row + 1'b1;
                        end
                    end else begin
                        rd_col <= rd_col + 1'b1;
                    end
                end
                mm_pkg::ENG_RELEASE: begin
                    bank_release <= 1'b1;
                    state        <= mm_pkg::ENG_IDLE;
                end
                default: begin
                    state <= mm_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    a_last_with_valid: assert property (@(posedge clk) disable iff (rst)
        c_last |-> c_valid);

    // Read bank must stay full for the whole computation
    a_full_while_run: assert property (@(posedge clk) disable iff (rst)
        (state == mm_pkg::ENG_RUN) |-> operands_full);

endmodule

// File: matrix_multiply_top.sv
module matrix_multiply_top #(
    parameter int DIM = 8,
    localparam int ROW_W = DIM * mm_pkg::ELEM_W,
    localparam int C_ROW_W = DIM * mm_pkg::RESULT_W,
    localparam int IDX_W = $clog2(DIM)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               a_valid,
    input  logic [ROW_W-1:0]   a_data,
    input  logic               b_valid,
    input  logic [ROW_W-1:0]   b_data,
    output logic               c_valid,
    output logic [C_ROW_W-1:0] c_data,
    output logic               c_last,
    output logic               ready,
    output logic               busy
);

    // Loader to buffer
    logic                 wr_en;
    mm_pkg::operand_sel_t wr_sel;
    logic [IDX_W-1:0]     wr_row;
    logic [ROW_W-1:0]     wr_data;
    logic                 fill_done;

    // Buffer to engine
    logic                 operands_full;
    logic [IDX_W-1:0]     rd_row;
    logic [IDX_W-1:0]     rd_col;
    logic [ROW_W-1:0]     a_row_data;
    logic [ROW_W-1:0]     b_col_data;
    logic                 bank_release;

    operand_loader #(
        .DIM(DIM)
    ) u_loader (
        .clk       (clk),
        .rst       (rst),
        .a_valid   (a_valid),
        .a_data    (a_data),
        .b_valid   (b_valid),
        .b_data    (b_data),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_row    (wr_row),
        .wr_data   (wr_data),
        .fill_done (fill_done)
    );

    operand_buffer #(
        .DIM(DIM)
    ) u_buffer (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_row        (wr_row),
        .wr_data       (wr_data),
        .fill_done     (fill_done),
        .rd_row        (rd_row),
        .rd_col        (rd_col),
        .bank_release  (bank_release),
        .a_row_data    (a_row_data),
        .b_col_data    (b_col_data),
        .operands_full (operands_full),
        .ready         (ready)
    );

    mac_engine #(
        .DIM(DIM)
    ) u_engine (
        .clk           (clk),
        .rst           (rst),
        .operands_full (operands_full),
        .a_row_data    (a_row_data),
        .b_col_data    (b_col_data),
        .rd_row        (rd_row),
        .rd_col        (rd_col),
        .bank_release  (bank_release),
        .c_valid       (c_valid),
        .c_data        (c_data),
        .c_last        (c_last),
        .busy          (busy)
    );

endmodule

// File: tb_matrix_multiply.sv
module tb_matrix_multiply;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DIM = 8;
    localparam int EW = mm_pkg::ELEM_W;
    localparam int RW = mm_pkg::RESULT_W;
    localparam int ROW_W = DIM * EW;
    localparam int C_ROW_W = DIM * RW;
    localparam int READY_LIMIT = 400;
    localparam int DRAIN_LIMIT = 2000;
    localparam int RUN_PAIRS = 20;

    logic               clk = 1'b0;
    logic               rst;
    logic               a_valid;
    logic [ROW_W-1:0]   a_data;
    logic               b_valid;
    logic [ROW_W-1:0]   b_data;
    logic               c_valid;
    logic [C_ROW_W-1:0] c_data;
    logic               c_last;
    logic               ready;
    logic               busy;

    logic [31:0]             seed = 32'd70927;
    logic signed [EW-1:0]    a_mat [DIM][DIM];
    logic signed [EW-1:0]    b_mat [DIM][DIM];
    logic [C_ROW_W-1:0]      exp_rows [$];
    int mismatches = 0;
    int other_errors = 0;
    int rows_checked = 0;
    int row_idx = 0;
    int pairs_sent = 0;
    int last_count = 0;
    int last_at_low = 0;
    int run_base = 0;
    bit low_seen = 1'b0;
    bit recover_seen = 1'b0;

    matrix_multiply_top #(
        .DIM(DIM)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .a_valid (a_valid),
        .a_data  (a_data),
        .b_valid (b_valid),
        .b_data  (b_data),
        .c_valid (c_valid),
        .c_data  (c_data),
        .c_last  (c_last),
        .ready   (ready),
        .busy    (busy)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [EW-1:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[23:16];
    endfunction

    // Mode 0 random, 1 all -128, 2 all 127, 3 mixed signs
    task automatic fill_matrices(input int mode);
        for (int i = 0; i < DIM; i++) begin
            for (int k = 0; k < DIM; k++) begin
                case (mode)
                    1: begin
                        a_mat[i][k] = 8'sh80;
                        b_mat[i][k] = 8'sh80;
                    end
                    2: begin
                        a_mat[i][k] = 8'sh7f;
                        b_mat[i][k] = 8'sh7f;
                    end
                    3: begin
                        a_mat[i][k] = ((i + k) % 2 == 0) ? 8'sh80 : 8'sh7f;
                        b_mat[i][k] = (k % 2 == 0) ? 8'sh80 : 8'sh7f;
                    end
                    default: begin
                        a_mat[i][k] = rand_byte();
                        b_mat[i][k] = rand_byte();
                    end
                endcase
            end
        end
    endtask

    // Expected C row with each element wrapped to the low 16 bits of the dot product
    function automatic logic [C_ROW_W-1:0] model_row(input int i);
        logic [C_ROW_W-1:0] row;
        int sum;
        for (int j = 0; j < DIM; j++) begin
            sum = 0;
            for (int k = 0; k < DIM; k++) begin
                sum += int'(a_mat[i][k]) * int'(b_mat[k][j]);
            end
            row[j*RW +: RW] = sum[RW-1:0];
        end
        return row;
    endfunction

    function automatic logic [ROW_W-1:0] pack_row(input bit is_b, input int idx);
        logic [ROW_W-1:0] row;
        for (int k = 0; k < DIM; k++) begin
            row[k*EW +: EW] = is_b ? b_mat[idx][k] : a_mat[idx][k];
        end
        return row;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d mismatches, %0d other errors, %0d rows checked, %0d pairs sent",
                 mismatches, other_errors, rows_checked, pairs_sent);
    endtask

    task automatic fail_timeout(input string why);
        other_errors++;
        $display("Timeout: %s", why);
        print_summary();
        $display("Errors found");
        $finish;
    endtask

    // Both streams may mix and pause while the host keeps the loader skid from overflowing
    task automatic send_pair(input bit mixed, input bit gaps);
        int ai;
        int bi;
        bit skid;
        bit da;
        bit db;
        logic [31:0] r;
        ai = 0;
        bi = 0;
        skid = 1'b0;
        for (int i = 0; i < DIM; i++) begin
            exp_rows.push_back(model_row(i));
        end
        pairs_sent++;
        while (ai < DIM || bi < DIM) begin
            r = lcg_next();
            if (!mixed) begin
                da = ai < DIM;
                db = !da;
            end else begin
                da = r[16] && ai < DIM;
                db = r[17] && bi < DIM;
                if (da && db && skid) begin
                    db = 1'b0;
                end
                if (!da && !db) begin
                    da = ai < DIM;
                    db = !da;
                end
            end
            if (gaps && r[21:19] == 3'd0) begin
                da = 1'b0;
                db = 1'b0;
            end
            @(posedge clk);
            a_valid <= da;
            b_valid <= db;
            if (da) begin
                a_data <= pack_row(1'b0, ai);
                ai++;
            end
            if (db) begin
                b_data <= pack_row(1'b1, bi);
                bi++;
            end
            skid = skid ? (da || db) : (da && db);
        end
        @(posedge clk);
        a_valid <= 1'b0;
        b_valid <= 1'b0;
        // Let fill_done land before ready is looked at again
        @(posedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready && n < READY_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!ready) begin
            fail_timeout("ready stayed low, no bank was freed");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rows.size() != 0 && n < DRAIN_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (exp_rows.size() != 0) begin
            fail_timeout("result rows still missing after the drain limit");
        end
    endtask

    // Result monitor sampled away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (c_valid) begin
                assert (exp_rows.size() > 0) else begin
                    $display("c_valid arrived with no pair pending in the model at %0t", $time);
                    other_errors++;
                end
                if (exp_rows.size() > 0) begin
                    assert (c_data === exp_rows[0]) else begin
                        $display("ERR %0t c_data: got %h expected %h", $time, c_data, exp_rows[0]);
                        mismatches++;
                    end
                    void'(exp_rows.pop_front());
                    rows_checked++;
                end
                check_bit("c_last", c_last, row_idx == DIM - 1);
                check_bit("busy", busy, 1'b1);
                row_idx = (row_idx == DIM - 1) ? 0 : row_idx + 1;
            end else begin
                check_bit("c_last", c_last, 1'b0);
            end
            if (c_last) begin
                last_count++;
            end
            if (!ready && pairs_sent - last_count >= 2) begin
                low_seen = 1'b1;
                last_at_low = last_count;
            end
            if (low_seen && ready && last_count > last_at_low) begin
                recover_seen = 1'b1;
            end
        end
    end

    initial begin
        rst = 1'b1;
        a_valid = 1'b0;
        b_valid = 1'b0;
        a_data = '0;
        b_data = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("ready", ready, 1'b1);
        check_bit("busy", busy, 1'b0);
        check_bit("c_valid", c_valid, 1'b0);
        check_bit("c_last", c_last, 1'b0);

        // One random pair, then the extreme operand sets
        for (int mode = 0; mode < 4; mode++) begin
            fill_matrices(mode);
            wait_ready();
            send_pair(1'b0, 1'b0);
            wait_drain();
        end

        fill_matrices(0);
        wait_ready();
        send_pair(1'b1, 1'b1);
        wait_drain();

        // Back-to-back pairs sent as soon as a bank is free
        run_base = last_count;
        for (int p = 0; p < RUN_PAIRS; p++) begin
            fill_matrices(0);
            wait_ready();
            send_pair(1'b1, p % 2 == 1);
        end
        wait_drain();
        repeat (4) @(negedge clk);

        assert (low_seen) else begin
            $display("ready never went low while two pairs were pending");
            other_errors++;
        end
        assert (recover_seen) else begin
            $display("ready did not come back high after a c_last");
            other_errors++;
        end
        assert (last_count - run_base == RUN_PAIRS) else begin
            $display("ERR %0t c_last count: got %0d expected %0d",
                     $time, last_count - run_base, RUN_PAIRS);
            mismatches++;
        end
        assert (last_count == pairs_sent) else begin
            $display("ERR %0t total c_last count: got %0d expected %0d",
                     $time, last_count, pairs_sent);
            mismatches++;
        end
        check_bit("busy", busy, 1'b0);

        print_summary();
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
mm_pkg.sv
operand_loader.sv
operand_buffer.sv
mac_engine.sv
matrix_multiply_top.sv
tb_matrix_multiply.sv

// File: run.sh
#!/bin/bash
# Build and run the matrix multiplier testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_matrix_multiply -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
